//--- mips_core.f
hw/mips_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/mips_core.sv
test/tb_mips_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mips_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mips_core -f mips_core.f -o sim_mips_core
./obj_dir/sim_mips_core > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
   exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- test/tb_mips_core.sv
// mips_core testbench with instruction and data memories, random program generator,
// sequential reference model and in-order checks of the store stream
`timescale 1ns/10ps

module tb_mips_core;

   localparam mips_pkg::word_t text_start = 32'h0040_0000;
   // 150 random instructions, 2 nops, 32 register stores, 1 stopper
   localparam int prog_words = 185;

   logic                 clk;
   logic                 rst_b;
   mips_pkg::inst_addr_t imem_addr;
   mips_pkg::word_t      imem_data;
   mips_pkg::inst_addr_t dmem_addr;
   mips_pkg::word_t      dmem_wdata;
   logic                 dmem_we;
   mips_pkg::word_t      dmem_rdata;
   logic                 halted;

   // program image that doubles as the instruction memory
   mips_pkg::word_t      prog [256];
   mips_pkg::inst_addr_t imem_idx;
   mips_pkg::word_t      dmem [256];
   logic                 mem_init;

   // reference model state and expected store stream
   mips_pkg::word_t      model_regs [32];
   mips_pkg::word_t      model_mem [256];
   mips_pkg::inst_addr_t exp_addr [$];
   mips_pkg::word_t      exp_data [$];

   logic [31:0]          rng_state;
   string                test_name;
   int                   errors;
   int                   checks;
   logic                 timed_out;
   // owned by the store monitor
   int                   store_idx;
   int                   store_errors;
   int                   stores_seen;

   mips_core #(
      .text_start (text_start)
   ) uut (
      .clk        (clk),
      .rst_b      (rst_b),
      .imem_addr  (imem_addr),
      .imem_data  (imem_data),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // instruction fetch outside the image returns a nop
   always_comb begin
      imem_idx = imem_addr - text_start[31:2];
      if (imem_idx < 30'd256)
         imem_data = prog[imem_idx[7:0]];
      else
         imem_data = '0;
   end

   assign dmem_rdata = dmem[dmem_addr[7:0]];

   always @(posedge clk) begin
      if (mem_init) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(i);
         end
      end else if (dmem_we) begin
         dmem[dmem_addr[7:0]] <= dmem_wdata;
      end
   end

   // every store is compared in order against the model stream
   always @(negedge clk) begin
      if (!rst_b) begin
         store_idx = 0;
      end else if (dmem_we) begin
         stores_seen++;
         if (store_idx >= exp_addr.size()) begin
            store_errors++;
            $display("%s: unexpected store to word %h after the program's last store",
                     test_name, dmem_addr);
         end else begin
            if (dmem_addr !== exp_addr[store_idx]) begin
               store_errors++;
               $display("[ERROR] %s store %0d address: expected %h, actual %h",
                        test_name, store_idx, exp_addr[store_idx], dmem_addr);
            end
            if (dmem_wdata !== exp_data[store_idx]) begin
               store_errors++;
               $display("[ERROR] %s store %0d data: expected %h, actual %h",
                        test_name, store_idx, exp_data[store_idx], dmem_wdata);
            end
         end
         store_idx++;
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // initial data memory contents spread over the whole index
   function automatic mips_pkg::word_t fill_word(input int i);
      return (mips_pkg::word_t'(i) * 32'h9e37_79b9) ^ 32'h3c6e_f372;
   endfunction

   // a source written by one of the two previous instructions falls back to r0
   function automatic mips_pkg::reg_addr_t pick_src(input logic [4:0] cand,
                                                    input mips_pkg::reg_addr_t l1,
                                                    input mips_pkg::reg_addr_t l2);
      if (cand != 5'd0 && (cand == l1 || cand == l2))
         return 5'd0;
      return cand;
   endfunction

   task automatic build_program(input mips_pkg::word_t stop_word);
      logic [31:0]         r;
      logic [31:0]         s;
      logic [5:0]          fn;
      logic [5:0]          op;
      mips_pkg::reg_addr_t rs;
      mips_pkg::reg_addr_t rt;
      mips_pkg::reg_addr_t rd;
      mips_pkg::reg_addr_t dest;
      mips_pkg::reg_addr_t last1;
      mips_pkg::reg_addr_t last2;
      logic [15:0]         offset;
      last1 = 5'd0;
      last2 = 5'd0;
      for (int i = 0; i < 150; i++) begin
         r = next_rand();
         s = next_rand();
         rs = pick_src(s[4:0], last1, last2);
         rt = pick_src(s[12:8], last1, last2);
         // r0 as destination checks that its writes are dropped
         rd = r[8:4];
         dest = rd;
         // loads and stores stay inside words 0 to 15
         offset = {10'd0, r[17:14], 2'b00};
         fn = mips_pkg::fn_addu;
         op = mips_pkg::op_addiu;
         case (r[3:0])
            4'd0: fn = mips_pkg::fn_add;
            4'd1: fn = mips_pkg::fn_addu;
            4'd2: fn = mips_pkg::fn_sub;
            4'd3: fn = mips_pkg::fn_subu;
            4'd4: fn = mips_pkg::fn_and;
            4'd5: fn = mips_pkg::fn_or;
            4'd6: fn = mips_pkg::fn_xor;
            4'd7: fn = mips_pkg::fn_sll;
            4'd8: fn = mips_pkg::fn_srl;
            4'd9: fn = mips_pkg::fn_sra;
            4'd10: op = mips_pkg::op_addiu;
            4'd11: op = mips_pkg::op_andi;
            4'd12: op = mips_pkg::op_ori;
            default: op = mips_pkg::op_xori;
         endcase
         if (r[3:0] <= 4'd6)
            prog[i] = {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
         else if (r[3:0] <= 4'd9)
            // shifts leave the rs field zero and take the amount from shamt
            prog[i] = {mips_pkg::op_rtype, 5'd0, rt, rd, r[13:9], fn};
         else if (r[3:0] <= 4'd13)
            prog[i] = {op, rs, rd, r[31:16]};
         else if (r[3:0] == 4'd14)
            prog[i] = {mips_pkg::op_lw, 5'd0, rd, offset};
         else begin
            prog[i] = {mips_pkg::op_sw, 5'd0, rt, offset};
            dest = 5'd0;
         end
         last2 = last1;
         last1 = dest;
      end
      // two nops keep the register dump clear of the last writes
      prog[150] = '0;
      prog[151] = '0;
      // dump r0..r31 to words 64..95
      for (int i = 0; i < 32; i++) begin
         prog[152 + i] = {mips_pkg::op_sw, 5'd0, i[4:0], 7'd0, 1'b1, 1'b0, i[4:0], 2'b00};
      end
      prog[184] = stop_word;
      // stores behind the stopper must never reach memory
      for (int i = prog_words; i < 256; i++) begin
         prog[i] = {mips_pkg::op_sw, 5'd0, 5'd31, 6'd0, i[7:0], 2'b00};
      end
   endtask

   task automatic set_reg(input mips_pkg::reg_addr_t n, input mips_pkg::word_t v);
      if (n != 5'd0)
         model_regs[n] = v;
   endtask

   // one instruction of the sequential reference
   task automatic model_step(input mips_pkg::word_t w, output logic stop);
      mips_pkg::reg_addr_t rs;
      mips_pkg::reg_addr_t rt;
      mips_pkg::reg_addr_t rd;
      logic [4:0]          sh;
      mips_pkg::word_t     a;
      mips_pkg::word_t     b;
      mips_pkg::word_t     sx;
      mips_pkg::word_t     zx;
      mips_pkg::word_t     addr;
      rs = w[25:21];
      rt = w[20:16];
      rd = w[15:11];
      sh = w[10:6];
      a = model_regs[rs];
      b = model_regs[rt];
      sx = {{16{w[15]}}, w[15:0]};
      zx = {16'h0000, w[15:0]};
      addr = a + sx;
      stop = 1'b0;
      case (w[31:26])
         mips_pkg::op_rtype: begin
            case (w[5:0])
               mips_pkg::fn_add, mips_pkg::fn_addu: set_reg(rd, a + b);
               mips_pkg::fn_sub, mips_pkg::fn_subu: set_reg(rd, a - b);
               mips_pkg::fn_and: set_reg(rd, a & b);
               mips_pkg::fn_or:  set_reg(rd, a | b);
               mips_pkg::fn_xor: set_reg(rd, a ^ b);
               mips_pkg::fn_sll: set_reg(rd, b << sh);
               mips_pkg::fn_srl: set_reg(rd, b >> sh);
               mips_pkg::fn_sra: set_reg(rd, $signed(b) >>> sh);
               // syscall and reserved functions
               default: stop = 1'b1;
            endcase
         end
         mips_pkg::op_addiu: set_reg(rt, a + sx);
         mips_pkg::op_andi:  set_reg(rt, a & zx);
         mips_pkg::op_ori:   set_reg(rt, a | zx);
         mips_pkg::op_xori:  set_reg(rt, a ^ zx);
         mips_pkg::op_lw:    set_reg(rt, model_mem[addr[9:2]]);
         mips_pkg::op_sw: begin
            model_mem[addr[9:2]] = b;
            exp_addr.push_back(addr[31:2]);
            exp_data.push_back(b);
         end
         default: stop = 1'b1;
      endcase
   endtask

   task automatic run_model();
      logic stop;
      int   pc;
      exp_addr.delete();
      exp_data.delete();
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         model_mem[i] = fill_word(i);
      end
      stop = 1'b0;
      pc = 0;
      while (!stop && pc < prog_words) begin
         model_step(prog[pc], stop);
         pc++;
      end
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
   endtask

   // reset, load one program, run it to halt and check the store count
   task automatic run_program(input mips_pkg::word_t stop_word, input string name);
      int cycles;
      int limit;
      test_name = name;
      @(posedge clk);
      #1 rst_b = 1'b0;
      build_program(stop_word);
      run_model();
      mem_init = 1'b1;
      @(posedge clk);
      #1 mem_init = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      checks++;
      if (halted !== 1'b0)
         report_mismatch("halted in reset", 32'd0, {31'd0, halted});
      if (dmem_we !== 1'b0)
         report_mismatch("dmem_we in reset", 32'd0, {31'd0, dmem_we});
      if (imem_addr !== text_start[31:2])
         report_mismatch("imem_addr in reset", {2'b00, text_start[31:2]}, {2'b00, imem_addr});
      @(posedge clk);
      #1 rst_b = 1'b1;
      cycles = 0;
      limit = prog_words + 40;
      while (!halted && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("%s: timeout, halted did not rise within %0d cycles", name, limit);
         timed_out = 1'b1;
      end else begin
         // keep watching for stray stores after the halt
         repeat (10) @(negedge clk);
         checks++;
         if (store_idx != exp_addr.size())
            report_mismatch("store count", exp_addr.size(), store_idx);
         if (halted !== 1'b1)
            report_mismatch("halted held", 32'd1, {31'd0, halted});
      end
   endtask

   initial begin
      rst_b = 1'b0;
      mem_init = 1'b0;
      rng_state = 32'h6b46_c862;
      errors = 0;
      checks = 0;
      timed_out = 1'b0;
      store_errors = 0;
      stores_seen = 0;
      test_name = "startup";
      run_program({mips_pkg::op_rtype, 20'd0, mips_pkg::fn_syscall}, "syscall run");
      // opcode 0x3f is reserved
      if (!timed_out)
         run_program(32'hfc00_0000, "reserved run");
      $display("summary: %0d checks, %0d errors, %0d stores seen, %0d store errors",
               checks, errors, stores_seen, store_errors);
      if (errors == 0 && store_errors == 0 && !timed_out) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- hw/mips_core.sv
// mips_core: five stage integer pipeline top level
// wires fetch, decode, register file, execute and memory/writeback together
`timescale 1ns/10ps

module mips_core #(
   // reset value of the pc, byte address
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_pkg::inst_addr_t imem_addr,
   input  mips_pkg::word_t      imem_data,
   output mips_pkg::inst_addr_t dmem_addr,
   output mips_pkg::word_t      dmem_wdata,
   output logic                 dmem_we,
   input  mips_pkg::word_t      dmem_rdata,
   output logic                 halted
);

   // fetch to decode
   mips_pkg::word_t     id_inst;
   logic                id_valid;
   logic                stop_fetch;

   // register file read side
   mips_pkg::reg_addr_t rs_num;
   mips_pkg::reg_addr_t rt_num;
   mips_pkg::word_t     rs_data;
   mips_pkg::word_t     rt_data;

   // decode to execute
   mips_pkg::word_t     ex_op1;
   mips_pkg::word_t     ex_rt_data;
   mips_pkg::word_t     ex_imm;
   mips_pkg::alu_sel_t  ex_alu_sel;
   logic                ex_use_imm;
   logic                ex_load;
   logic                ex_store;
   logic                ex_we;
   logic                ex_stop;
   mips_pkg::reg_addr_t ex_dest;

   // execute to memory
   mips_pkg::word_t     mem_result;
   mips_pkg::word_t     mem_store_data;
   logic                mem_load;
   logic                mem_store;
   logic                mem_we;
   logic                mem_stop;
   mips_pkg::reg_addr_t mem_dest;

   // writeback into the register file
   logic                wb_we;
   mips_pkg::reg_addr_t wb_addr;
   mips_pkg::word_t     wb_data;

   fetch_stage #(
      .text_start (text_start)
   ) u_fetch (
      .clk        (clk),
      .rst_b      (rst_b),
      .stop_fetch (stop_fetch),
      .imem_addr  (imem_addr),
      .imem_data  (imem_data),
      .id_inst    (id_inst),
      .id_valid   (id_valid)
   );

   decode_stage u_decode (
      .clk        (clk),
      .rst_b      (rst_b),
      .id_inst    (id_inst),
      .id_valid   (id_valid),
      .rs_data    (rs_data),
      .rt_data    (rt_data),
      .rs_num     (rs_num),
      .rt_num     (rt_num),
      .stop_fetch (stop_fetch),
      .ex_op1     (ex_op1),
      .ex_rt_data (ex_rt_data),
      .ex_imm     (ex_imm),
      .ex_alu_sel (ex_alu_sel),
      .ex_use_imm (ex_use_imm),
      .ex_load    (ex_load),
      .ex_store   (ex_store),
      .ex_we      (ex_we),
      .ex_stop    (ex_stop),
      .ex_dest    (ex_dest)
   );

   regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_num  (rs_num),
      .rt_num  (rt_num),
      .wb_we   (wb_we),
      .wb_addr (wb_addr),
      .wb_data (wb_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   execute_stage u_execute (
      .clk            (clk),
      .rst_b          (rst_b),
      .ex_op1         (ex_op1),
      .ex_rt_data     (ex_rt_data),
      .ex_imm         (ex_imm),
      .ex_alu_sel     (ex_alu_sel),
      .ex_use_imm     (ex_use_imm),
      .ex_load        (ex_load),
      .ex_store       (ex_store),
      .ex_we          (ex_we),
      .ex_stop        (ex_stop),
      .ex_dest        (ex_dest),
      .mem_result     (mem_result),
      .mem_store_data (mem_store_data),
      .mem_load       (mem_load),
      .mem_store      (mem_store),
      .mem_we         (mem_we),
      .mem_stop       (mem_stop),
      .mem_dest       (mem_dest)
   );

   mem_wb_stage u_mem_wb (
      .clk            (clk),
      .rst_b          (rst_b),
      .mem_result     (mem_result),
      .mem_store_data (mem_store_data),
      .mem_load       (mem_load),
      .mem_store      (mem_store),
      .mem_we         (mem_we),
      .mem_stop       (mem_stop),
      .mem_dest       (mem_dest),
      .dmem_rdata     (dmem_rdata),
      .dmem_addr      (dmem_addr),
      .dmem_wdata     (dmem_wdata),
      .dmem_we        (dmem_we),
      .wb_we          (wb_we),
      .wb_addr        (wb_addr),
      .wb_data        (wb_data),
      .halted         (halted)
   );

endmodule

//--- hw/mem_wb_stage.sv
// mem_wb_stage: data memory access, memory/writeback register,
// writeback data select and the sticky halted flag
`timescale 1ns/10ps

module mem_wb_stage (
   input  logic                 clk,
   input  logic                 rst_b,
   input  mips_pkg::word_t      mem_result,
   input  mips_pkg::word_t      mem_store_data,
   input  logic                 mem_load,
   input  logic                 mem_store,
   input  logic                 mem_we,
   input  logic                 mem_stop,
   input  mips_pkg::reg_addr_t  mem_dest,
   input  mips_pkg::word_t      dmem_rdata,
   output mips_pkg::inst_addr_t dmem_addr,
   output mips_pkg::word_t      dmem_wdata,
   output logic                 dmem_we,
   output logic                 wb_we,
   output mips_pkg::reg_addr_t  wb_addr,
   output mips_pkg::word_t      wb_data,
   output logic                 halted
);

   // byte address to word address
   assign dmem_addr  = mem_result[31:2];
   assign dmem_wdata = mem_store_data;
   assign dmem_we    = mem_store;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         wb_we  <= 1'b0;
         halted <= 1'b0;
      end else begin
         wb_we <= mem_we;
         // held until the next reset
         if (mem_stop)
            halted <= 1'b1;
      end
   end

   // read data comes back in the same cycle as the address
   always_ff @(posedge clk) begin
      wb_addr <= mem_dest;
      wb_data <= mem_load ? dmem_rdata : mem_result;
   end

endmodule

//--- hw/execute_stage.sv
// execute_stage: second operand select, alu and the execute/memory register
`timescale 1ns/10ps

module execute_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::word_t     ex_op1,
   input  mips_pkg::word_t     ex_rt_data,
   input  mips_pkg::word_t     ex_imm,
   input  mips_pkg::alu_sel_t  ex_alu_sel,
   input  logic                ex_use_imm,
   input  logic                ex_load,
   input  logic                ex_store,
   input  logic                ex_we,
   input  logic                ex_stop,
   input  mips_pkg::reg_addr_t ex_dest,
   output mips_pkg::word_t     mem_result,
   output mips_pkg::word_t     mem_store_data,
   output logic                mem_load,
   output logic                mem_store,
   output logic                mem_we,
   output logic                mem_stop,
   output mips_pkg::reg_addr_t mem_dest
);

   mips_pkg::word_t op2;
   mips_pkg::word_t alu_result;

   // immediate ops, loads and stores use the extended immediate
   assign op2 = ex_use_imm ? ex_imm : ex_rt_data;

   alu u_alu (
      .op1     (ex_op1),
      .op2     (op2),
      .alu_sel (ex_alu_sel),
      .result  (alu_result)
   );

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         mem_load  <= 1'b0;
         mem_store <= 1'b0;
         mem_we    <= 1'b0;
         mem_stop  <= 1'b0;
      end else begin
         mem_load  <= ex_load;
         mem_store <= ex_store;
         mem_we    <= ex_we;
         mem_stop  <= ex_stop;
      end
   end

   // result doubles as the byte address for lw and sw
   always_ff @(posedge clk) begin
      mem_result     <= alu_result;
      mem_store_data <= ex_rt_data;
      mem_dest       <= ex_dest;
   end

endmodule

//--- hw/decode_stage.sv
// decode_stage: field split, control decode, immediate extension
// and the decode/execute pipeline register
`timescale 1ns/10ps

module decode_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::word_t     id_inst,
   input  logic                id_valid,
   input  mips_pkg::word_t     rs_data,
   input  mips_pkg::word_t     rt_data,
   output mips_pkg::reg_addr_t rs_num,
   output mips_pkg::reg_addr_t rt_num,
   output logic                stop_fetch,
   output mips_pkg::word_t     ex_op1,
   output mips_pkg::word_t     ex_rt_data,
   output mips_pkg::word_t     ex_imm,
   output mips_pkg::alu_sel_t  ex_alu_sel,
   output logic                ex_use_imm,
   output logic                ex_load,
   output logic                ex_store,
   output logic                ex_we,
   output logic                ex_stop,
   output mips_pkg::reg_addr_t ex_dest
);

   logic [5:0]          opcode;
   logic [5:0]          funct;
   logic [4:0]          shamt;
   logic [15:0]         imm16;
   mips_pkg::reg_addr_t rd_num;
   mips_pkg::alu_sel_t  alu_sel;
   logic                use_imm;
   logic                is_load;
   logic                is_store;
   logic                writes;
   logic                stop;
   logic                zero_ext;
   logic                is_shift;
   mips_pkg::word_t     imm_ext;
   mips_pkg::word_t     op1;
   mips_pkg::reg_addr_t dest;

   // instruction fields
   assign opcode = id_inst[31:26];
   assign rs_num = id_inst[25:21];
   assign rt_num = id_inst[20:16];
   assign rd_num = id_inst[15:11];
   assign shamt  = id_inst[10:6];
   assign funct  = id_inst[5:0];
   assign imm16  = id_inst[15:0];

   assign is_shift = (opcode == mips_pkg::op_rtype) &&
                     (funct == mips_pkg::fn_sll || funct == mips_pkg::fn_srl ||
                      funct == mips_pkg::fn_sra);

   always_comb begin
      alu_sel  = mips_pkg::alu_add;
      use_imm  = 1'b1;
      is_load  = 1'b0;
      is_store = 1'b0;
      writes   = 1'b1;
      stop     = 1'b0;
      zero_ext = 1'b0;
      case (opcode)
         mips_pkg::op_rtype: begin
            use_imm = 1'b0;
            case (funct)
               // add traps nothing here, same as addu
               mips_pkg::fn_add, mips_pkg::fn_addu: alu_sel = mips_pkg::alu_add;
               mips_pkg::fn_sub, mips_pkg::fn_subu: alu_sel = mips_pkg::alu_sub;
               mips_pkg::fn_and:     alu_sel = mips_pkg::alu_and;
               mips_pkg::fn_or:      alu_sel = mips_pkg::alu_or;
               mips_pkg::fn_xor:     alu_sel = mips_pkg::alu_xor;
               mips_pkg::fn_sll:     alu_sel = mips_pkg::alu_sll;
               mips_pkg::fn_srl:     alu_sel = mips_pkg::alu_srl;
               mips_pkg::fn_sra:     alu_sel = mips_pkg::alu_sra;
               mips_pkg::fn_syscall: stop = 1'b1;
               // reserved function code halts like syscall
               default:              stop = 1'b1;
            endcase
         end
         mips_pkg::op_addiu: alu_sel = mips_pkg::alu_add;
         mips_pkg::op_andi: begin
            alu_sel  = mips_pkg::alu_and;
            zero_ext = 1'b1;
         end
         mips_pkg::op_ori: begin
            alu_sel  = mips_pkg::alu_or;
            zero_ext = 1'b1;
         end
         mips_pkg::op_xori: begin
            alu_sel  = mips_pkg::alu_xor;
            zero_ext = 1'b1;
         end
         // address = rs + sign extended offset
         mips_pkg::op_lw: is_load = 1'b1;
         mips_pkg::op_sw: is_store = 1'b1;
         default: stop = 1'b1;
      endcase
      if (stop || is_store)
         writes = 1'b0;
   end

   // sign extension for addiu and offsets, zero for logic immediates
   assign imm_ext = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

   // shifts take the shift amount as the first operand
   assign op1 = is_shift ? {27'd0, shamt} : rs_data;

   // rd for register ops, rt for immediates and loads
   assign dest = !writes                         ? mips_pkg::reg_zero :
                 (opcode == mips_pkg::op_rtype) ? rd_num : rt_num;

   assign stop_fetch = id_valid & stop;

   // controls are cleared for a bubble
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_load  <= 1'b0;
         ex_store <= 1'b0;
         ex_we    <= 1'b0;
         ex_stop  <= 1'b0;
      end else begin
         ex_load  <= id_valid & is_load;
         ex_store <= id_valid & is_store;
         ex_we    <= id_valid & writes;
         ex_stop  <= id_valid & stop;
      end
   end

   always_ff @(posedge clk) begin
      ex_op1     <= op1;
      ex_rt_data <= rt_data;
      ex_imm     <= imm_ext;
      ex_alu_sel <= alu_sel;
      ex_use_imm <= use_imm;
      ex_dest    <= dest;
   end

endmodule

//--- hw/fetch_stage.sv
// fetch_stage: pc register and fetch/decode pipeline register
// freezes for good once decode asks fetch to stop
`timescale 1ns/10ps

module fetch_stage #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic                 clk,
   input  logic                 rst_b,
   input  logic                 stop_fetch,
   output mips_pkg::inst_addr_t imem_addr,
   input  mips_pkg::word_t      imem_data,
   output mips_pkg::word_t      id_inst,
   output logic                 id_valid
);

   // pc kept as a word address
   mips_pkg::inst_addr_t pc;
   // sticky, set by the first stop request
   logic                 stopped;
   logic                 freeze;

   assign freeze    = stop_fetch | stopped;
   assign imem_addr = pc;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc       <= text_start[31:2];
         stopped  <= 1'b0;
         id_valid <= 1'b0;
      end else begin
         if (stop_fetch)
            stopped <= 1'b1;
         if (!freeze)
            pc <= pc + 30'd1;
         // a bubble replaces the instruction behind the stopper
         id_valid <= ~freeze;
      end
   end

   // instruction word, qualified by id_valid
   always_ff @(posedge clk) begin
      id_inst <= imem_data;
   end

endmodule

//--- hw/regfile.sv
// regfile: 32 x 32 register file, two reads, one write
// r0 reads zero, a same cycle write passes through to the reads
`timescale 1ns/10ps

module regfile (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::reg_addr_t rs_num,
   input  mips_pkg::reg_addr_t rt_num,
   input  logic                wb_we,
   input  mips_pkg::reg_addr_t wb_addr,
   input  mips_pkg::word_t     wb_data,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data
);

   mips_pkg::word_t regs [32];
   logic            do_write;

   // writes to r0 dropped so it stays zero
   assign do_write = wb_we && (wb_addr != mips_pkg::reg_zero);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (do_write) begin
         regs[wb_addr] <= wb_data;
      end
   end

   // bypass the value being written this cycle
   assign rs_data = (do_write && wb_addr == rs_num) ? wb_data : regs[rs_num];
   assign rt_data = (do_write && wb_addr == rt_num) ? wb_data : regs[rt_num];

endmodule

//--- hw/alu.sv
// alu: add, subtract, logic ops and the three shifts
`timescale 1ns/10ps

module alu (
   input  mips_pkg::word_t    op1,
   input  mips_pkg::word_t    op2,
   input  mips_pkg::alu_sel_t alu_sel,
   output mips_pkg::word_t    result
);

   // shift distance from the low five bits of op1
   logic [4:0] shift_amt;

   assign shift_amt = op1[4:0];

   always_comb begin
      case (alu_sel)
         mips_pkg::alu_add: result = op1 + op2;
         mips_pkg::alu_sub: result = op1 - op2;
         mips_pkg::alu_and: result = op1 & op2;
         mips_pkg::alu_or:  result = op1 | op2;
         mips_pkg::alu_xor: result = op1 ^ op2;
         mips_pkg::alu_sll: result = op2 << shift_amt;
         mips_pkg::alu_srl: result = op2 >> shift_amt;
         // arithmetic, sign bit copied in
         mips_pkg::alu_sra: result = $signed(op2) >>> shift_amt;
         default:           result = op1 + op2;
      endcase
   end

endmodule

//--- hw/mips_pkg.sv
// shared widths, opcodes, function codes and alu selects for the mips core
package mips_pkg;

   // data word: register values, immediates, alu results
   typedef logic [31:0] word_t;
   // word address into instruction or data memory
   typedef logic [29:0] inst_addr_t;
   // register number
   typedef logic [4:0]  reg_addr_t;
   // alu operation select
   typedef logic [3:0]  alu_sel_t;

   // alu operations
   localparam alu_sel_t alu_add = 4'd0;
   localparam alu_sel_t alu_sub = 4'd1;
   localparam alu_sel_t alu_and = 4'd2;
   localparam alu_sel_t alu_or  = 4'd3;
   localparam alu_sel_t alu_xor = 4'd4;
   localparam alu_sel_t alu_sll = 4'd5;
   localparam alu_sel_t alu_srl = 4'd6;
   localparam alu_sel_t alu_sra = 4'd7;

   // primary opcodes, bits 31:26
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_addiu = 6'h09;
   localparam logic [5:0] op_andi  = 6'h0c;
   localparam logic [5:0] op_ori   = 6'h0d;
   localparam logic [5:0] op_xori  = 6'h0e;
   localparam logic [5:0] op_lw    = 6'h23;
   localparam logic [5:0] op_sw    = 6'h2b;

   // function codes for op_rtype, bits 5:0
   localparam logic [5:0] fn_sll     = 6'h00;
   localparam logic [5:0] fn_srl     = 6'h02;
   localparam logic [5:0] fn_sra     = 6'h03;
   localparam logic [5:0] fn_syscall = 6'h0c;
   localparam logic [5:0] fn_add     = 6'h20;
   localparam logic [5:0] fn_addu    = 6'h21;
   localparam logic [5:0] fn_sub     = 6'h22;
   localparam logic [5:0] fn_subu    = 6'h23;
   localparam logic [5:0] fn_and     = 6'h24;
   localparam logic [5:0] fn_or      = 6'h25;
   localparam logic [5:0] fn_xor     = 6'h26;

   // destination for instructions that write nothing
   localparam reg_addr_t reg_zero = 5'd0;

endpackage
